// File: vlog.f
+incdir+verif
rtl/filter_pkg.sv
rtl/scan_if.sv
rtl/line_buffer.sv
rtl/window_row.sv
rtl/window_sum.sv
rtl/box_filter_top.sv
verif/box_filter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module box_filter_tb \
  -o box_filter_sim || { echo "Verilator build failed"; exit 1; }
./obj_dir/box_filter_sim > sim.log 2>&1 || echo "Simulator exited with an error"
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verif/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [31:0]    lcg_state = 32'hf293385f;
pixel_t         frame_img [IMG_ROWS][IMG_COLS];
logic [SUM_W:0] exp_q [$]; // Last flag sits above the sum

function automatic logic [31:0] lcg_next(input logic [31:0] s);
  return s * 32'd1664525 + 32'd1013904223;
endfunction

// Every window inside the frame whose newest pixel comes before pixel npix, in raster order
task automatic queue_expected(input int npix);
  int   acc;
  logic lst;
  for (int r = WIN-1; r < IMG_ROWS; r++) begin
    for (int c = WIN-1; c < IMG_COLS; c++) begin
      if (r * IMG_COLS + c < npix) begin
        acc = 0;
        for (int dr = 0; dr < WIN; dr++) begin
          for (int dc = 0; dc < WIN; dc++) begin
            acc += int'(frame_img[r-dr][c-dc]);
          end
        end
        lst = (r == IMG_ROWS-1) && (c == IMG_COLS-1); // Bottom right corner ends the frame
        exp_q.push_back({lst, sum_t'(acc)});
      end
    end
  end
endtask

task automatic check_output(input sum_t sum, input logic lst);
  logic [SUM_W:0] want;
  want = exp_q.pop_front();
  assert (sum == want[SUM_W-1:0]) else begin
    $display("ERR %0t: sum %0d, expected %0d", $time, sum, want[SUM_W-1:0]);
    err_cnt++;
  end
  assert (lst == want[SUM_W]) else begin
    $display("ERR %0t: last flag %0b, expected %0b", $time, lst, want[SUM_W]);
    err_cnt++;
  end
  sums_checked++;
endtask

`endif

// File: verif/box_filter_tb.sv
`timescale 1ns/100ps

module box_filter_tb;
  import filter_pkg::*;

  localparam int WAIT_LIMIT = 500; // Cycles that any single wait may take
  localparam int FRAME_PIX  = IMG_ROWS * IMG_COLS;

  logic   clk = 1'b0;
  logic   rst_n;
  logic   frame_clear_i;
  logic   in_req_i;
  pixel_t in_pix_i;
  logic   in_ack_o;
  logic   out_ack_i;
  logic   out_req_o;
  sum_t   out_sum_o;
  logic   out_last_o;

  int   err_cnt = 0;
  int   timeout_cnt = 0;
  int   sums_checked = 0;
  int   in_gap [FRAME_PIX];
  int   ack_gap [FRAME_PIX];
  int   cyc = 0;
  int   ack_rise_cyc = -100;
  int   req_rises = 0;
  logic ack_seen = 1'b0;
  logic req_seen = 1'b0;

  `include "tb_model.svh"

  always #5 clk = ~clk;

  box_filter_top UUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_clear_i (frame_clear_i),
    .in_req_i      (in_req_i),
    .in_pix_i      (in_pix_i),
    .in_ack_o      (in_ack_o),
    .out_ack_i     (out_ack_i),
    .out_req_o     (out_req_o),
    .out_sum_o     (out_sum_o),
    .out_last_o    (out_last_o)
  );

  // Handshake order and latency are sampled half a cycle away from the active edge
  always @(negedge clk) begin
    cyc++;
    if (rst_n && in_ack_o && !ack_seen) begin
      assert (!out_req_o && !req_seen) else begin
        $display("ERR %0t: input acknowledge rose while a sum was offered", $time);
        err_cnt++;
      end
      ack_rise_cyc = cyc;
    end
    if (rst_n && out_req_o && !req_seen) begin
      req_rises++;
      assert (cyc - ack_rise_cyc == 2) else begin
        $display("ERR %0t: output request %0d cycles after acknowledge", $time,
                 cyc - ack_rise_cyc);
        err_cnt++;
      end
    end
    ack_seen = in_ack_o;
    req_seen = out_req_o;
  end

  task automatic finish_run();
    $display("Errors: %0d, timeouts: %0d, sums checked: %0d", err_cnt, timeout_cnt,
             sums_checked);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  function automatic logic watched(input bit out_side);
    return out_side ? out_req_o : in_ack_o;
  endfunction

  task automatic wait_for(input bit out_side, input logic level);
    int cycles;
    cycles = 0;
    while (watched(out_side) !== level && cycles < WAIT_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (watched(out_side) !== level) begin
      $display("Timeout at %0t: %s did not go to %0b", $time,
               out_side ? "out_req_o" : "in_ack_o", level);
      timeout_cnt++;
      finish_run();
    end
  endtask

  task automatic fill_frame(input bit ramp);
    for (int r = 0; r < IMG_ROWS; r++) begin
      for (int c = 0; c < IMG_COLS; c++) begin
        lcg_state = lcg_next(lcg_state);
        frame_img[r][c] = ramp ? pixel_t'(r * IMG_COLS + c) : lcg_state[31:24];
      end
    end
  endtask

  task automatic drive_pixels(input int npix);
    for (int i = 0; i < npix; i++) begin
      repeat (in_gap[i]) @(posedge clk);
      in_pix_i <= frame_img[i / IMG_COLS][i % IMG_COLS];
      in_req_i <= 1'b1;
      wait_for(1'b0, 1'b1);
      in_req_i <= 1'b0;
      wait_for(1'b0, 1'b0);
    end
  endtask

  task automatic collect_sums(input int n);
    for (int k = 0; k < n; k++) begin
      wait_for(1'b1, 1'b1);
      check_output(out_sum_o, out_last_o);
      repeat (ack_gap[k]) @(posedge clk); // Slow sink
      out_ack_i <= 1'b1;
      wait_for(1'b1, 1'b0);
      out_ack_i <= 1'b0;
    end
  endtask

  task automatic run_frame(input int npix, input int max_delay);
    int n_exp;
    int rises_before;
    for (int i = 0; i < FRAME_PIX; i++) begin
      lcg_state = lcg_next(lcg_state);
      in_gap[i]  = int'(lcg_state[23:16]) % (max_delay + 1);
      ack_gap[i] = int'(lcg_state[15:8]) % (max_delay + 1);
    end
    queue_expected(npix);
    n_exp = exp_q.size();
    rises_before = req_rises;
    fork
      drive_pixels(npix);
      collect_sums(n_exp);
    join
    repeat (8) @(posedge clk);
    assert (req_rises - rises_before == n_exp && !out_req_o &&
            (npix < FRAME_PIX ||
             req_rises - rises_before == (IMG_ROWS-WIN+1) * (IMG_COLS-WIN+1))) else begin
      $display("ERR %0t: %0d sums produced, %0d expected", $time,
               req_rises - rises_before, n_exp);
      err_cnt++;
    end
  endtask

  initial begin
    rst_n         <= 1'b0;
    frame_clear_i <= 1'b0;
    in_req_i      <= 1'b0;
    in_pix_i      <= '0;
    out_ack_i     <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (!in_ack_o && !out_req_o && !out_last_o) else begin
      $display("ERR %0t: handshake outputs not idle after reset", $time);
      err_cnt++;
    end
    @(posedge clk);

    fill_frame(1'b1);
    run_frame(FRAME_PIX, 0);
    fill_frame(1'b0);
    run_frame(FRAME_PIX, 0);
    fill_frame(1'b0);
    run_frame(FRAME_PIX, 7); // Random gaps on both sides

    // Abandon a frame part way through row 5 and start over
    fill_frame(1'b0);
    run_frame(5 * IMG_COLS + 7, 2);
    frame_clear_i <= 1'b1;
    @(posedge clk);
    frame_clear_i <= 1'b0;
    @(posedge clk);
    fill_frame(1'b0);
    run_frame(FRAME_PIX, 3);

    finish_run();
  end

endmodule

// File: rtl/box_filter_top.sv
`timescale 1ns/100ps

module box_filter_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               frame_clear_i,
  input  logic               in_req_i,
  input  filter_pkg::pixel_t in_pix_i,
  output logic               in_ack_o,
  input  logic               out_ack_i,
  output logic               out_req_o,
  output filter_pkg::sum_t   out_sum_o,
  output logic               out_last_o
);
  import filter_pkg::*;

  scan_if  scan ();
  column_t taps [WIN]; // One row of window taps per instance

  line_buffer u_line_buffer (
    .clk           (clk),
    .rst_n         (rst_n),
    .frame_clear_i (frame_clear_i),
    .in_req_i      (in_req_i),
    .in_pix_i      (in_pix_i),
    .in_ack_o      (in_ack_o),
    .scan          (scan.src)
  );

  // Row r of the window takes element r of the column, oldest row first
  for (genvar r = 0; r < WIN; r++) begin : g_row
    window_row u_window_row (
      .clk        (clk),
      .rst_n      (rst_n),
      .pixel_in_i (scan.column[r]),
      .scan       (scan.row),
      .taps_o     (taps[r])
    );
  end

  window_sum u_window_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .taps_i     (taps),
    .scan       (scan.sink),
    .out_ack_i  (out_ack_i),
    .out_sum_o  (out_sum_o),
    .out_last_o (out_last_o),
    .out_req_o  (out_req_o)
  );

endmodule

// File: rtl/window_sum.sv
`timescale 1ns/100ps

module window_sum (
  input  logic                clk,
  input  logic                rst_n,
  input  filter_pkg::column_t taps_i [filter_pkg::WIN],
  scan_if.sink                scan,
  input  logic                out_ack_i,
  output filter_pkg::sum_t    out_sum_o,
  output logic                out_last_o,
  output logic                out_req_o
);
  import filter_pkg::*;

  out_state_t state_q;
  logic       pend_q;      // Taps advanced on the last edge and hold a full window
  logic       pend_last_q;
  sum_t       row_sum [WIN];
  sum_t       win_sum;

  // First level adds along each row, second level adds the row sums
  always_comb begin
    for (int r = 0; r < WIN; r++) begin
      row_sum[r] = '0;
      for (int t = 0; t < WIN; t++) begin
        row_sum[r] = row_sum[r] + sum_t'(taps_i[r][t]);
      end
    end
    win_sum = '0;
    for (int r = 0; r < WIN; r++) begin
      win_sum = win_sum + row_sum[r];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_q      <= 1'b0;
      pend_last_q <= 1'b0;
    end else begin
      pend_q      <= scan.shift && scan.win_ok;
      pend_last_q <= scan.last;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= OUT_IDLE;
      out_last_o <= 1'b0;
    end else begin
      case (state_q)
        OUT_IDLE: begin
          if (pend_q) begin
            state_q    <= OUT_REQ;
            out_last_o <= pend_last_q;
          end
        end
        OUT_REQ: begin
          if (out_ack_i) begin
            state_q <= OUT_WAIT_LOW;
          end
        end
        OUT_WAIT_LOW: begin
          if (!out_ack_i) begin
            state_q    <= OUT_IDLE;
            out_last_o <= 1'b0;
          end
        end
        default: begin
          state_q <= OUT_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == OUT_IDLE) && pend_q) begin
      out_sum_o <= win_sum; // Held stable through the whole handshake
    end
  end

  assign out_req_o = (state_q == OUT_REQ);

  // Raised straight from the shift so the input side cannot slip in another pixel
  assign scan.busy = (scan.shift && scan.win_ok) || pend_q || (state_q != OUT_IDLE);

endmodule

// File: rtl/window_row.sv
`timescale 1ns/100ps

module window_row (
  input  logic                clk,
  input  logic                rst_n,
  input  filter_pkg::pixel_t  pixel_in_i,
  scan_if.row                 scan,
  output filter_pkg::column_t taps_o
);
  import filter_pkg::*;

  // Tap 0 is the leftmost pixel of the window, tap WIN-1 the newest
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      taps_o <= '0;
    end else if (scan.shift) begin
      for (int t = 0; t < WIN-1; t++) begin
        taps_o[t] <= taps_o[t+1];
      end
      taps_o[WIN-1] <= pixel_in_i;
    end
  end

endmodule

// File: rtl/line_buffer.sv
`timescale 1ns/100ps

module line_buffer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               frame_clear_i,
  input  logic               in_req_i,
  input  filter_pkg::pixel_t in_pix_i,
  output logic               in_ack_o,
  scan_if.src                scan
);
  import filter_pkg::*;

  in_state_t state_q;
  col_t      col_q;
  row_t      row_q;
  pixel_t    line_mem_q [WIN-1][IMG_COLS]; // Entry 0 holds the older of the two rows
  logic      accept;
  logic      col_end;
  logic      row_end;

  // Frame clear wins over a pending request on the same edge
  assign accept  = in_req_i && (state_q == IN_IDLE) && !scan.busy && !frame_clear_i;
  assign col_end = (col_q == col_t'(IMG_COLS - 1));
  assign row_end = (row_q == row_t'(IMG_ROWS - 1));

  assign in_ack_o   = (state_q != IN_IDLE);
  assign scan.shift = (state_q == IN_ACK); // Only the first cycle of the acknowledge

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IN_IDLE;
    end else begin
      case (state_q)
        IN_IDLE: begin
          if (accept) begin
            state_q <= IN_ACK;
          end
        end
        IN_ACK: begin
          state_q <= IN_WAIT_LOW;
        end
        IN_WAIT_LOW: begin
          if (!in_req_i) begin
            state_q <= IN_IDLE; // Acknowledge drops once the source lets go
          end
        end
        default: begin
          state_q <= IN_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (frame_clear_i) begin
      col_q <= '0;
      row_q <= '0;
    end else if (accept) begin
      if (col_end) begin
        col_q <= '0;
        row_q <= row_end ? '0 : row_q + 1'b1; // Wraps at the end of the frame
      end else begin
        col_q <= col_q + 1'b1;
      end
    end
  end

  // The older rows at this column are read out before the new pixel pushes them up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < WIN-1; k++) begin
        for (int c = 0; c < IMG_COLS; c++) begin
          line_mem_q[k][c] <= '0;
        end
      end
      scan.column <= '0;
      scan.win_ok <= 1'b0;
      scan.last   <= 1'b0;
    end else if (accept) begin
      for (int k = 0; k < WIN-1; k++) begin
        scan.column[k] <= line_mem_q[k][col_q];
      end
      for (int k = 0; k < WIN-2; k++) begin
        line_mem_q[k][col_q] <= line_mem_q[k+1][col_q];
      end
      line_mem_q[WIN-2][col_q] <= in_pix_i;
      scan.column[WIN-1]       <= in_pix_i;

      // Window is complete once two full rows and two columns lie behind this pixel
      scan.win_ok <= (row_q >= row_t'(WIN - 1)) && (col_q >= col_t'(WIN - 1));
      scan.last   <= row_end && col_end;
    end
  end

endmodule

// File: rtl/scan_if.sv
`timescale 1ns/100ps

interface scan_if;
  import filter_pkg::*;

  column_t column; // One pixel for each window row
  logic    shift;  // High for one cycle per accepted pixel
  logic    win_ok;
  logic    last;
  logic    busy;   // A sum is pending on the output side

  modport src (
    output column,
    output shift,
    output win_ok,
    output last,
    input  busy
  );

  modport row (input column, input shift);

  modport sink (
    input  shift,
    input  win_ok,
    input  last,
    output busy
  );
endinterface

// File: rtl/filter_pkg.sv
package filter_pkg;

  localparam int PIX_W    = 8;
  localparam int IMG_COLS = 16;
  localparam int IMG_ROWS = 12;
  localparam int WIN      = 3;
  localparam int SUM_W    = 12; // Holds nine times the largest pixel

  typedef logic [PIX_W-1:0] pixel_t;
  typedef logic [SUM_W-1:0] sum_t;
  typedef logic [3:0]       col_t;
  typedef logic [3:0]       row_t;

  // Element 0 is the oldest row and element WIN-1 the current pixel
  typedef pixel_t [WIN-1:0] column_t;

  typedef enum logic [1:0] {
    IN_IDLE,
    IN_ACK,
    IN_WAIT_LOW
  } in_state_t;

  typedef enum logic [1:0] {
    OUT_IDLE,
    OUT_REQ,
    OUT_WAIT_LOW
  } out_state_t;

endpackage
